// File: sources.f
+incdir+include
src/ppu_span_pkg.sv
src/ppu_mem_pkg.sv
src/ppu_ifs.sv
src/sync_fifo.sv
src/tilemap_ram.sv
src/span_coord_gen.sv
src/tile_agu.sv
src/tile_out_port.sv
src/ppu_tile_top.sv
tb/tb_ppu_tile_top.sv

// File: Makefile
# Verilator build and run of the tile fetch testbench

SIM  := obj_dir/Vtb_ppu_tile_top
SRCS := $(filter %.sv,$(shell cat sources.f)) include/tb_tile_model.svh

.PHONY: all run clean

all: run

# rebuilt only when a source file or the file list changes
$(SIM): sources.f $(SRCS)
	verilator --binary --timing -j 0 --top-module tb_ppu_tile_top -f sources.f \
		-o Vtb_ppu_tile_top

# the pass line in the log decides the exit status
run: $(SIM)
	$(SIM) | tee sim.log
	grep -q '\*\*\* TEST PASSED \*\*\*' sim.log

clean:
	rm -rf obj_dir sim.log

// File: include/tb_tile_model.svh
// testbench LFSR, reference tilemap and expected tile record model
// included into the body of the testbench module
`ifndef TB_TILE_MODEL_SVH
`define TB_TILE_MODEL_SVH

// ------------------------------
// random numbers
// ------------------------------

// galois LFSR state, polynomial x^32 + x^22 + x^2 + x + 1 in reversed form
logic [31:0] lfsr_state = 32'h4a5a2c62;

function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
endfunction

// one LFSR step per bit taken, the first bit taken ends up as the msb
function automatic int rand_bits(input int n);
	int r;
	r = 0;
	for (int i = 0; i < n; i++) begin
		lfsr_state = lfsr_next(lfsr_state);
		r = (r << 1) | int'(lfsr_state[0]);
	end
	return r;
endfunction

// ------------------------------
// reference model
// ------------------------------

// mirror of every byte written into the tilemap RAM
tile_num_t ref_map [4096];

// records still to come, packed as discard, v pos, u pos, tile number
logic [16:0] exp_q [$];

// one record computed from the span rules for the pixel at u, v
function automatic logic [16:0] expected_record(input int u, input int v,
		input span_type_e stype, input int ptr, input int texsize, input bit tilesize);
	int pf;
	int ts;
	int idx;
	int addr;
	bit disc;
	// playfield is 64 px square scaled up by texsize, tiles are 8 or 16 px
	pf   = 64 << texsize;
	ts   = tilesize ? 16 : 8;
	// clip spans drop anything at or past the playfield edge
	disc = (stype == SPAN_CLIP) && (u >= pf || v >= pf);
	// wrap spans fold the coordinate back into the playfield before lookup
	idx  = ((u % pf) / ts) + ((v % pf) / ts) * (pf / ts);
	addr = (ptr + idx) % 4096;
	if (disc)
		return {1'b1, 4'(v % ts), 4'(u % ts), 8'h00};
	return {1'b0, 4'(v % ts), 4'(u % ts), ref_map[12'(addr)]};
endfunction

// queue one record per pixel, u steps by one and wraps at the 9 bit coordinate
task automatic expect_span(input int u0, input int v0, input int count,
		input span_type_e stype, input int ptr, input int texsize, input bit tilesize);
	// a none span yields nothing at all
	if (stype == SPAN_NONE)
		return;
	for (int i = 0; i <= count; i++)
		exp_q.push_back(expected_record((u0 + i) % 512, v0, stype, ptr, texsize, tilesize));
endtask

`endif

// File: tb/tb_ppu_tile_top.sv
// testbench for the tile fetch stage with clock, reset, watchdog and host driver
// plus a random consumer, five span tests and the closing report
`timescale 1ns/1ps

module tb_ppu_tile_top
	import ppu_span_pkg::*, ppu_mem_pkg::*;
();
	// every span is at most 64 px, the watchdog is sized from that
	localparam int NUM_SPANS    = 22;
	localparam int MAX_PIXELS   = NUM_SPANS * 64;
	localparam int MAP_WRITES   = 4096 + NUM_SPANS * 16;
	localparam int WATCHDOG_CYC = MAX_PIXELS * 40 + MAP_WRITES + 2000;
	localparam int DRAIN_LIMIT  = 64 * 40;
	// the record queue holds four entries, a record in the output port is already counted
	localparam int HELD_RECORDS = 4;
	localparam int MODE_FREE     = 0;
	localparam int MODE_EDGE     = 1;
	localparam int MODE_HIGH_PTR = 2;

	logic       clk           = 1'b0;
	logic       rst_n         = 1'b0;
	logic       span_req      = 1'b0;
	coord_t     span_u0       = '0;
	coord_t     span_v0       = '0;
	count_t     span_count    = '0;
	span_type_e span_type     = SPAN_NONE;
	map_addr_t  span_ptr      = '0;
	texsize_t   span_texsize  = '0;
	logic       span_tilesize = 1'b0;
	logic       tile_ack      = 1'b0;
	logic       map_wen       = 1'b0;
	map_addr_t  map_waddr     = '0;
	tile_num_t  map_wdata     = '0;
	logic       span_ack;
	logic       tile_req;
	tile_pos_t  tile_u;
	tile_pos_t  tile_v;
	tile_num_t  tile_num;
	logic       tile_discard;

	int errors         = 0;
	int checks         = 0;
	int rx_count       = 0;
	int tests_run      = 0;
	int tests_failed   = 0;
	int ack_delay_bits = 2;

	`include "tb_tile_model.svh"

	ppu_tile_top i_ppu_tile_top (
		.clk           (clk),
		.rst_n         (rst_n),
		.span_req      (span_req),
		.span_u0       (span_u0),
		.span_v0       (span_v0),
		.span_count    (span_count),
		.span_type     (span_type),
		.span_ptr      (span_ptr),
		.span_texsize  (span_texsize),
		.span_tilesize (span_tilesize),
		.span_ack      (span_ack),
		.tile_req      (tile_req),
		.tile_u        (tile_u),
		.tile_v        (tile_v),
		.tile_num      (tile_num),
		.tile_discard  (tile_discard),
		.tile_ack      (tile_ack),
		.map_wen       (map_wen),
		.map_waddr     (map_waddr),
		.map_wdata     (map_wdata)
	);

	// 8 ns clock period
	always #4 clk = ~clk;

	initial begin : watchdog
		repeat (WATCHDOG_CYC) @(posedge clk);
		$display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYC);
		$display("*** TEST FAILED ***");
		$finish;
	end

	// ------------------------------
	// consumer
	// ------------------------------

	// compare one record with the head of the model queue
	task automatic check_record();
		logic [16:0] want;
		rx_count++;
		if (exp_q.size() == 0) begin
			$display("%0t: tile record arrived while none was expected", $time);
			errors++;
			return;
		end
		want = exp_q.pop_front();
		checks++;
		if (tile_discard !== want[16]) begin
			$display("[ERROR] %0t tile_discard got %b expected %b", $time, tile_discard, want[16]);
			errors++;
		end
		if (tile_v !== want[15:12]) begin
			$display("[ERROR] %0t tile_v got %h expected %h", $time, tile_v, want[15:12]);
			errors++;
		end
		if (tile_u !== want[11:8]) begin
			$display("[ERROR] %0t tile_u got %h expected %h", $time, tile_u, want[11:8]);
			errors++;
		end
		// a discard record carries no tile number
		if (!want[16] && tile_num !== want[7:0]) begin
			$display("[ERROR] %0t tile_num got %h expected %h", $time, tile_num, want[7:0]);
			errors++;
		end
	endtask

	// four-phase answer with random delays before each ack edge
	always begin : consumer
		@(negedge clk);
		if (rst_n && tile_req) begin
			check_record();
			repeat (rand_bits(ack_delay_bits)) @(negedge clk);
			tile_ack = 1'b1;
			do
				@(negedge clk);
			while (tile_req);
			repeat (rand_bits(ack_delay_bits)) @(negedge clk);
			tile_ack = 1'b0;
		end
	end

	// ------------------------------
	// host
	// ------------------------------

	// random tile numbers over the whole map or at n random addresses
	task automatic load_map(input int n, input bit whole);
		int addr;
		for (int i = 0; i < n; i++) begin
			addr = whole ? i : rand_bits(12);
			@(negedge clk);
			map_wen   = 1'b1;
			map_waddr = map_addr_t'(addr);
			map_wdata = tile_num_t'(rand_bits(8));
			ref_map[12'(addr)] = map_wdata;
		end
		@(negedge clk);
		map_wen = 1'b0;
	endtask

	// one span handshake, then wait until every expected record has come back
	task automatic run_span(input int u0, input int v0, input int count,
			input span_type_e stype, input int ptr, input int texsize, input bit tilesize);
		int pixels;
		int rx_before;
		int waited;
		pixels = (stype == SPAN_NONE) ? 0 : count + 1;
		expect_span(u0, v0, count, stype, ptr, texsize, tilesize);
		rx_before = rx_count;
		@(negedge clk);
		span_u0       = coord_t'(u0);
		span_v0       = coord_t'(v0);
		span_count    = count_t'(count);
		span_type     = stype;
		span_ptr      = map_addr_t'(ptr);
		span_texsize  = texsize_t'(texsize);
		span_tilesize = tilesize;
		span_req      = 1'b1;
		do
			@(negedge clk);
		while (!span_ack);
		// the consumer has counted this edge's record after the step
		#1;
		// once every pixel is issued, only records still in the queue can be missing
		checks++;
		if (pixels - (rx_count - rx_before) > HELD_RECORDS) begin
			$display("%0t: span_ack rose with %0d of %0d records not yet delivered",
				$time, pixels - (rx_count - rx_before), pixels);
			errors++;
		end
		@(negedge clk);
		span_req = 1'b0;
		do
			@(negedge clk);
		while (span_ack);
		waited = 0;
		while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		checks++;
		if (exp_q.size() != 0) begin
			$display("%0t: %0d expected tile records never arrived", $time, exp_q.size());
			errors++;
			exp_q.delete();
		end else if (rx_count - rx_before != pixels) begin
			$display("[ERROR] %0t record count got %0d expected %0d",
				$time, rx_count - rx_before, pixels);
			errors++;
		end
	endtask

	// draw a random span, refresh part of the map, then run it
	task automatic random_span(input span_type_e stype, input int mode);
		int texsize;
		int pf;
		int u0;
		int v0;
		int count;
		int ptr;
		bit tilesize;
		texsize  = rand_bits(2);
		tilesize = (rand_bits(1) != 0);
		pf       = 64 << texsize;
		count    = rand_bits(6);
		ptr      = rand_bits(12);
		u0       = rand_bits(9);
		v0       = rand_bits(9);
		// start just inside the right edge so the span runs across it
		if (mode == MODE_EDGE)
			u0 = pf - 1 - rand_bits(5);
		// pointer near the top of the map so the address sum wraps
		if (mode == MODE_HIGH_PTR)
			ptr = 4095 - rand_bits(4);
		// most clip rows lie inside the playfield, so both record kinds show up
		if (stype == SPAN_CLIP && rand_bits(2) != 0)
			v0 = v0 % pf;
		load_map(16, 1'b0);
		run_span(u0, v0, count, stype, ptr, texsize, tilesize);
	endtask

	task automatic finish_test(input string name, input int err_before);
		tests_run++;
		if (errors == err_before) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d errors", tests_run, name, errors - err_before);
		end
	endtask

	// ------------------------------
	// test sequence
	// ------------------------------

	initial begin : main
		int err_before;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// test 1 checks idle outputs, then a none span
		err_before = errors;
		checks++;
		if (tile_req !== 1'b0) begin
			$display("[ERROR] %0t tile_req got %b expected 0", $time, tile_req);
			errors++;
		end
		checks++;
		if (span_ack !== 1'b0) begin
			$display("[ERROR] %0t span_ack got %b expected 0", $time, span_ack);
			errors++;
		end
		load_map(4096, 1'b1);
		run_span(rand_bits(9), rand_bits(9), rand_bits(9), SPAN_NONE, rand_bits(12),
			rand_bits(2), 1'b0);
		repeat (20) @(negedge clk);
		checks++;
		if (rx_count != 0) begin
			$display("%0t: tile records appeared after a span of type none", $time);
			errors++;
		end
		finish_test("reset and none span", err_before);

		err_before = errors;
		for (int i = 0; i < 8; i++)
			random_span(SPAN_WRAP, (i % 2 == 0) ? MODE_EDGE : MODE_FREE);
		finish_test("wrap spans", err_before);

		err_before = errors;
		for (int i = 0; i < 6; i++)
			random_span(SPAN_CLIP, MODE_EDGE);
		finish_test("clip spans", err_before);

		err_before = errors;
		for (int i = 0; i < 4; i++)
			random_span(SPAN_WRAP, MODE_HIGH_PTR);
		finish_test("pointer wrap", err_before);

		// long ack delays back the record queue up into the span
		err_before = errors;
		ack_delay_bits = 4;
		for (int i = 0; i < 4; i++)
			random_span((i % 2 == 1) ? SPAN_CLIP : SPAN_WRAP, MODE_EDGE);
		finish_test("slow consumer", err_before);

		$display("tests %0d, failed %0d, checks %0d, records %0d, errors %0d",
			tests_run, tests_failed, checks, rx_count, errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// File: src/ppu_tile_top.sv
// background tile fetch stage top level
// span input, address unit with tilemap, record output
`timescale 1ns/1ps

module ppu_tile_top
	import ppu_span_pkg::*, ppu_mem_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	// host span handshake
	input  logic       span_req,
	input  coord_t     span_u0,
	input  coord_t     span_v0,
	input  count_t     span_count,
	input  span_type_e span_type,
	input  map_addr_t  span_ptr,
	input  texsize_t   span_texsize,
	input  logic       span_tilesize,
	output logic       span_ack,
	// consumer tile record handshake
	output logic       tile_req,
	output tile_pos_t  tile_u,
	output tile_pos_t  tile_v,
	output tile_num_t  tile_num,
	output logic       tile_discard,
	input  logic       tile_ack,
	// tilemap load port
	input  logic       map_wen,
	input  map_addr_t  map_waddr,
	input  tile_num_t  map_wdata
);
	span_if    span_sig ();
	coord_if   coord_sig ();
	map_bus_if map_sig ();
	tinfo_if   tinfo_sig ();

	// ------------------------------
	// input side
	// ------------------------------

	span_coord_gen i_span_coord_gen (
		.clk           (clk),
		.rst_n         (rst_n),
		.span_req      (span_req),
		.span_u0       (span_u0),
		.span_v0       (span_v0),
		.span_count    (span_count),
		.span_type     (span_type),
		.span_ptr      (span_ptr),
		.span_texsize  (span_texsize),
		.span_tilesize (span_tilesize),
		.span_ack      (span_ack),
		.span          (span_sig.source),
		.coord         (coord_sig.source)
	);

	// ------------------------------
	// processing
	// ------------------------------

	tile_agu i_tile_agu (
		.clk   (clk),
		.rst_n (rst_n),
		.span  (span_sig.sink),
		.coord (coord_sig.sink),
		.bus   (map_sig.master),
		.tinfo (tinfo_sig.source)
	);

	tilemap_ram i_tilemap_ram (
		.clk       (clk),
		.map_wen   (map_wen),
		.map_waddr (map_waddr),
		.map_wdata (map_wdata),
		.bus       (map_sig.slave)
	);

	// ------------------------------
	// output side
	// ------------------------------

	tile_out_port i_tile_out_port (
		.clk          (clk),
		.rst_n        (rst_n),
		.tinfo        (tinfo_sig.sink),
		.tile_req     (tile_req),
		.tile_u       (tile_u),
		.tile_v       (tile_v),
		.tile_num     (tile_num),
		.tile_discard (tile_discard),
		.tile_ack     (tile_ack)
	);

endmodule

// File: src/tile_out_port.sv
// tile record stream to consumer four-phase handshake
`timescale 1ns/1ps

module tile_out_port
	import ppu_span_pkg::*, ppu_mem_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	tinfo_if.sink     tinfo,
	output logic      tile_req,
	output tile_pos_t tile_u,
	output tile_pos_t tile_v,
	output tile_num_t tile_num,
	output logic      tile_discard,
	input  logic      tile_ack
);
	typedef enum logic [1:0] {
		OUT_IDLE,
		OUT_REQ_HIGH,
		OUT_WAIT_LOW
	} state_e;

	state_e state;

	// a record is popped only between handshakes
	assign tinfo.rdy = (state == OUT_IDLE);
	assign tile_req  = (state == OUT_REQ_HIGH);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= OUT_IDLE;
		end else begin
			case (state)
				OUT_IDLE: begin
					if (tinfo.vld)
						state <= OUT_REQ_HIGH;
				end
				// req falls in the cycle after ack is seen high
				OUT_REQ_HIGH: begin
					if (tile_ack)
						state <= OUT_WAIT_LOW;
				end
				// the next record waits for the consumer to drop ack
				OUT_WAIT_LOW: begin
					if (!tile_ack)
						state <= OUT_IDLE;
				end
				default: state <= OUT_IDLE;
			endcase
		end
	end

	// fields stay stable for the whole handshake
	always_ff @(posedge clk) begin
		if (tinfo.vld && tinfo.rdy) begin
			tile_u       <= tinfo.u;
			tile_v       <= tinfo.v;
			tile_num     <= tinfo.num;
			tile_discard <= tinfo.discard;
		end
	end

endmodule

// File: src/tile_agu.sv
// span bookkeeping, tilemap address generation, bounds handling and record queues
`timescale 1ns/1ps

module tile_agu
	import ppu_span_pkg::*, ppu_mem_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	span_if.sink       span,
	coord_if.sink      coord,
	map_bus_if.master  bus,
	tinfo_if.source    tinfo
);
	count_t     remaining;
	logic       done;
	logic [3:0] log_pf;
	logic [2:0] tile_shift;
	logic [3:0] row_shift;
	coord_t     pf_mask;
	logic       out_of_bounds;
	logic       discard;
	map_addr_t  u_idx;
	map_addr_t  v_idx;
	map_addr_t  tile_index;
	tile_pos_t  pos_mask;
	logic       issue_ok;
	logic       accept;
	logic       pop;
	logic       pop_num;
	logic       tilenum_empty;
	logic       tinfo_full;
	logic       tinfo_empty;
	logic [8:0] rec_in;
	logic [8:0] rec_out;

	// ------------------------------
	// span bookkeeping
	// ------------------------------

	// done goes low for the length of a fetching span, a none span stays done
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			done      <= 1'b1;
			remaining <= '0;
		end else if (span.start) begin
			done      <= (span.stype == SPAN_NONE);
			remaining <= span.count;
		end else if (accept) begin
			remaining <= remaining - 1'b1;
			// the last pixel has been issued
			if (remaining == '0)
				done <= 1'b1;
		end
	end

	assign span.done = done;

	// ------------------------------
	// address generation
	// ------------------------------

	// playfield is 64 to 512 px square, tiles are 8 or 16 px
	assign log_pf     = 4'(PF_LOG_BASE) + 4'(span.texsize);
	assign tile_shift = span.tilesize ? 3'd4 : 3'd3;
	assign row_shift  = log_pf - 4'(tile_shift);
	assign pf_mask    = ~({$bits(coord_t){1'b1}} << log_pf);

	// any coordinate bit above the playfield means the pixel lies outside it
	assign out_of_bounds = |((coord.u | coord.v) & ~pf_mask);
	assign discard       = (span.stype == SPAN_CLIP) && out_of_bounds;

	// wrapped coordinates in tile units, rows are playfield/tile entries apart
	assign u_idx      = map_addr_t'((coord.u & pf_mask) >> tile_shift);
	assign v_idx      = map_addr_t'((coord.v & pf_mask) >> tile_shift);
	assign tile_index = u_idx + (v_idx << row_shift);

	// the sum wraps at 12 bits, so a pointer near the top folds back to zero
	assign bus.addr = span.ptr + tile_index;

	// ------------------------------
	// handshaking
	// ------------------------------

	// issue only with no tile number queued or returning, which limits the
	// rate to one pixel every two cycles and leaves room for the reply
	assign issue_ok  = !done && coord.vld && tilenum_empty && !bus.data_vld && !tinfo_full;
	assign coord.rdy = issue_ok && (discard || bus.addr_rdy);
	assign bus.addr_vld = issue_ok && !discard;
	assign accept    = coord.vld && coord.rdy;

	// a discard record has no matching entry in the tile number queue
	assign pop     = tinfo.vld && tinfo.rdy;
	assign pop_num = pop && !tinfo.discard;

	// ------------------------------
	// record queues
	// ------------------------------

	assign pos_mask = span.tilesize ? 4'hf : 4'h7;
	assign rec_in   = {discard, coord.v[3:0] & pos_mask, coord.u[3:0] & pos_mask};

	sync_fifo #(
		.WIDTH ($bits(tile_num_t)),
		.DEPTH (TILENUM_DEPTH)
	) tilenum_q (
		.clk   (clk),
		.rst_n (rst_n),
		.wdata (bus.data),
		.wen   (bus.data_vld),
		.rdata (tinfo.num),
		.ren   (pop_num),
		.full  (),
		.empty (tilenum_empty)
	);

	// pushed at issue time, so it runs ahead of the tile numbers
	sync_fifo #(
		.WIDTH (2 * $bits(tile_pos_t) + 1),
		.DEPTH (TINFO_DEPTH)
	) tinfo_q (
		.clk   (clk),
		.rst_n (rst_n),
		.wdata (rec_in),
		.wen   (accept),
		.rdata (rec_out),
		.ren   (pop),
		.full  (tinfo_full),
		.empty (tinfo_empty)
	);

	assign tinfo.discard = rec_out[8];
	assign tinfo.v       = rec_out[7:4];
	assign tinfo.u       = rec_out[3:0];

	// a fetched record waits for its tile number, a discard goes straight out
	assign tinfo.vld = !tinfo_empty && (tinfo.discard || !tilenum_empty);

endmodule

// File: src/span_coord_gen.sv
// host span handshake and per-pixel coordinate generation
`timescale 1ns/1ps

module span_coord_gen
	import ppu_span_pkg::*, ppu_mem_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       span_req,
	input  coord_t     span_u0,
	input  coord_t     span_v0,
	input  count_t     span_count,
	input  span_type_e span_type,
	input  map_addr_t  span_ptr,
	input  texsize_t   span_texsize,
	input  logic       span_tilesize,
	output logic       span_ack,
	span_if.source     span,
	coord_if.source    coord
);
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_RUN,
		ST_ACK_HIGH
	} state_e;

	state_e     state;
	logic       start;
	logic       launch;
	coord_t     u;
	coord_t     v;
	count_t     count_q;
	span_type_e stype_q;
	map_addr_t  ptr_q;
	texsize_t   texsize_q;
	logic       tilesize_q;

	// a new span is taken only from idle, the host holds its fields until ack
	assign launch = (state == ST_IDLE) && span_req;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= ST_IDLE;
			start    <= 1'b0;
			span_ack <= 1'b0;
		end else begin
			start <= launch;
			case (state)
				ST_IDLE: begin
					if (span_req)
						state <= ST_RUN;
				end
				ST_RUN: begin
					// done still shows the previous span while start is high
					if (span.done && !start) begin
						state    <= ST_ACK_HIGH;
						span_ack <= 1'b1;
					end
				end
				ST_ACK_HIGH: begin
					// return to zero once the host has dropped its request
					if (!span_req) begin
						state    <= ST_IDLE;
						span_ack <= 1'b0;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// span fields and the running coordinate, u steps on each accepted pixel
	always_ff @(posedge clk) begin
		if (launch) begin
			u          <= span_u0;
			v          <= span_v0;
			count_q    <= span_count;
			stype_q    <= span_type;
			ptr_q      <= span_ptr;
			texsize_q  <= span_texsize;
			tilesize_q <= span_tilesize;
		end else if (coord.vld && coord.rdy) begin
			u <= u + 1'b1;
		end
	end

	assign span.start    = start;
	assign span.count    = count_q;
	assign span.stype    = stype_q;
	assign span.ptr      = ptr_q;
	assign span.texsize  = texsize_q;
	assign span.tilesize = tilesize_q;

	// coordinates are offered from the cycle after start until the span is done
	assign coord.u   = u;
	assign coord.v   = v;
	assign coord.vld = (state == ST_RUN) && !start && !span.done;

endmodule

// File: src/tilemap_ram.sv
// byte-wide tilemap memory, host write port and one-cycle read bus
`timescale 1ns/1ps

module tilemap_ram
	import ppu_mem_pkg::*;
(
	input  logic       clk,
	input  logic       map_wen,
	input  map_addr_t  map_waddr,
	input  tile_num_t  map_wdata,
	map_bus_if.slave   bus
);
	tile_num_t mem [MAP_DEPTH];
	tile_num_t data;
	logic      data_vld;
	logic      rd_take;

	// ------------------------------
	// read bus
	// ------------------------------

	// a host write owns the array for that cycle, so reads are held off
	assign bus.addr_rdy = !map_wen;
	assign rd_take      = bus.addr_vld && bus.addr_rdy;

	// ------------------------------
	// storage
	// ------------------------------

	always_ff @(posedge clk) begin
		if (map_wen)
			mem[map_waddr] <= map_wdata;
		// tile number comes back exactly one cycle after the address is taken
		if (rd_take)
			data <= mem[bus.addr];
		data_vld <= rd_take;
	end

	assign bus.data_vld = data_vld;
	assign bus.data     = data;

endmodule

// File: src/sync_fifo.sv
// small synchronous FIFO with a register array and occupancy count
`timescale 1ns/1ps

module sync_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 2
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic [WIDTH-1:0] wdata,
	input  logic             wen,
	output logic [WIDTH-1:0] rdata,
	input  logic             ren,
	output logic             full,
	output logic             empty
);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wptr;
	logic [PTR_W-1:0] rptr;
	logic [CNT_W-1:0] count;
	logic             push;
	logic             pop;

	// pointers wrap at DEPTH, which need not be a power of two
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	// writes into a full queue and reads from an empty one are dropped
	assign push = wen && !full;
	assign pop  = ren && !empty;

	always_ff @(posedge clk) begin
		if (push)
			mem[wptr] <= wdata;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wptr  <= '0;
			rptr  <= '0;
			count <= '0;
		end else begin
			if (push)
				wptr <= ptr_inc(wptr);
			if (pop)
				rptr <= ptr_inc(rptr);
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	// the oldest entry is always visible at the read side
	assign rdata = mem[rptr];
	assign full  = (count == CNT_W'(DEPTH));
	assign empty = (count == '0);

endmodule

// File: src/ppu_ifs.sv
// span, coordinate, tilemap bus and tile record interfaces
`timescale 1ns/1ps

// span descriptor from the coordinate generator to the address unit
interface span_if
	import ppu_span_pkg::*, ppu_mem_pkg::*;
();
	logic       start;
	count_t     count;
	span_type_e stype;
	map_addr_t  ptr;
	texsize_t   texsize;
	logic       tilesize;
	logic       done;

	modport source (output start, count, stype, ptr, texsize, tilesize, input done);
	modport sink (input start, count, stype, ptr, texsize, tilesize, output done);
endinterface

// per-pixel coordinate stream, one transfer when vld and rdy are both high
interface coord_if
	import ppu_span_pkg::*;
();
	coord_t u;
	coord_t v;
	logic   vld;
	logic   rdy;

	modport source (output u, v, vld, input rdy);
	modport sink (input u, v, vld, output rdy);
endinterface

// tilemap read bus, data comes back one cycle after the address is taken
interface map_bus_if
	import ppu_mem_pkg::*;
();
	logic      addr_vld;
	logic      addr_rdy;
	map_addr_t addr;
	logic      data_vld;
	tile_num_t data;

	modport master (output addr_vld, addr, input addr_rdy, data_vld, data);
	modport slave (input addr_vld, addr, output addr_rdy, data_vld, data);
endinterface

// finished tile records toward the output port
interface tinfo_if
	import ppu_span_pkg::*, ppu_mem_pkg::*;
();
	tile_pos_t u;
	tile_pos_t v;
	tile_num_t num;
	logic      discard;
	logic      vld;
	logic      rdy;

	modport source (output u, v, num, discard, vld, input rdy);
	modport sink (input u, v, num, discard, vld, output rdy);
endinterface

// File: src/ppu_mem_pkg.sv
// tilemap memory types and queue depths
package ppu_mem_pkg;

	// byte address into the tilemap RAM
	typedef logic [11:0] map_addr_t;

	// one tilemap entry is one tile number
	typedef logic [7:0] tile_num_t;

	// tilemap size in bytes, one full 12 bit address space
	localparam int MAP_DEPTH = 4096;

	// tile numbers returning from the tilemap, one issued plus one in flight
	localparam int TILENUM_DEPTH = 2;

	// per-pixel record queue, filled at issue time so it runs ahead of the
	// tile numbers
	localparam int TINFO_DEPTH = 4;

endpackage

// File: src/ppu_span_pkg.sv
// span descriptor types, coordinate widths and playfield constants
package ppu_span_pkg;

	// ------------------------------
	// coordinates and counts
	// ------------------------------

	// a pixel coordinate along u or v, covering the largest playfield
	typedef logic [8:0] coord_t;

	// number of pixels in a span minus one
	typedef logic [8:0] count_t;

	// position of a pixel inside its tile, top bit stays clear for 8 px tiles
	typedef logic [3:0] tile_pos_t;

	// ------------------------------
	// span descriptor fields
	// ------------------------------

	// none ends the span at once, wrap folds coordinates back into the playfield
	// and clip turns out-of-bounds pixels into discard records
	typedef enum logic [1:0] {
		SPAN_NONE = 2'd0,
		SPAN_WRAP = 2'd1,
		SPAN_CLIP = 2'd2
	} span_type_e;

	// log2 of the square playfield size, offset by the smallest size
	typedef logic [1:0] texsize_t;

	// log2 of the smallest playfield, 64 px square
	localparam int PF_LOG_BASE = 6;

endpackage
